/* verilog/fretboard_pkg.sv */
// six strings by five positions fill bits 29 to 0 of the note word and segment patterns are active low
package fretboard_pkg;

	//////////////////////////////
	// fretboard geometry
	localparam int NUM_STRINGS   = 6;
	localparam int NUM_FRETS     = 4;
	localparam int NUM_POSITIONS = NUM_FRETS + 1; // open plus one per bar
	localparam int NOTE_W        = 32;

	typedef logic [NUM_STRINGS-1:0]   string_mask_t; // bit 0 is the first string
	typedef logic [NUM_POSITIONS-1:0] fret_sel_t;    // one-hot with bit 0 for open

	// one beat worth of pad activity
	typedef struct packed {
		string_mask_t strings;
		fret_sel_t    frets;
	} chord_t;

	// bit position*6 + string set per struck string
	typedef logic [NOTE_W-1:0] note_t;

	//////////////////////////////
	// seven segment patterns
	typedef logic [6:0] segments_t; // gfedcba, low lights the segment

	localparam segments_t SEG_TABLE [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, // 0 1 2 3
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000, // 4 5 6 7
		7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011, // 8 9 A b
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110  // C d E F
	};

endpackage

/* verilog/recorder_pkg.sv */
// tempo values are in ticks and the tick length is set by the top level parameter tick_cycles
package recorder_pkg;

	//////////////////////////////
	// tempo
	localparam int NUM_SPEEDS = 8;

	typedef logic [2:0]  speed_t;
	typedef logic [11:0] beat_count_t; // holds up to 4095 ticks

	// 40, 60, 80, 100, 120, 140, 180 and 220 beats per minute at 1 ms ticks
	localparam beat_count_t BEAT_TICKS [NUM_SPEEDS] = '{
		12'd1500, 12'd1000, 12'd750, 12'd600,
		12'd500,  12'd429,  12'd333, 12'd273
	};

	//////////////////////////////
	// note memory
	localparam int MEM_DEPTH = 64;

	typedef logic [$clog2(MEM_DEPTH)-1:0] addr_t; // wraps 63 to 0

	//////////////////////////////
	// session
	typedef enum logic [2:0] {
		IDLE,
		ARMED,
		ARMED_RELEASE,
		RUN,
		RUN_RELEASE,
		DONE,
		DONE_RELEASE
	} session_state_t;

	typedef struct packed {
		logic recording;
		logic playing;
		logic rewind;    // hold the address at zero
	} session_t;

	// mode switch
	localparam logic MODE_PLAY   = 1'b0;
	localparam logic MODE_RECORD = 1'b1;

endpackage

/* verilog/beat_timer.sv */
// first beat lands BEAT_TICKS[speed] * tick_cycles cycles after reset and speed is sampled at each reload
module beat_timer import recorder_pkg::*; #(
	parameter int tick_cycles = 50000
) (
	input  logic   clk,
	input  logic   resetn,
	input  speed_t speed,
	output logic   beat
);

	localparam int PRESC_W = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;
	localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(tick_cycles - 1);

	logic [PRESC_W-1:0] presc;
	logic               tick;
	beat_count_t        ticks_left; // ticks until the next beat

	//////////////////////////////
	// tick prescaler
	assign tick = (presc == PRESC_LAST);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			presc <= '0;
		end else if (tick) begin
			presc <= '0;
		end else begin
			presc <= presc + 1'b1;
		end
	end

	//////////////////////////////
	// beat down counter
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ticks_left <= BEAT_TICKS[speed];
			beat       <= 1'b0;
		end else begin
			beat <= 1'b0; // single cycle pulse
			if (tick) begin
				if (ticks_left == beat_count_t'(1)) begin
					ticks_left <= BEAT_TICKS[speed]; // new tempo takes effect here
					beat       <= 1'b1;
				end else begin
					ticks_left <= ticks_left - 1'b1;
				end
			end
		end
	end

	beat_single_pulse: assert property (@(posedge clk) disable iff (!resetn) beat |=> !beat)
		else $error("beat held for more than one cycle");

endmodule

/* verilog/chord_capture.sv */
// pads are expected debounced and the pads of the beat cycle itself count toward the note being closed
module chord_capture import fretboard_pkg::*; (
	input  logic                 clk,
	input  logic                 resetn,
	input  string_mask_t         strings,
	input  logic [NUM_FRETS-1:0] frets,
	input  logic                 beat,
	output note_t                note
);

	chord_t    held;    // gathered since the last beat
	chord_t    chord;   // held plus this cycle
	fret_sel_t pressed; // highest bar right now

	// highest pressed bar wins, open when no bar is down
	function automatic fret_sel_t top_bar(logic [NUM_FRETS-1:0] bars);
		fret_sel_t sel;
		sel = fret_sel_t'(1);
		for (int b = 0; b < NUM_FRETS; b++) begin
			if (bars[b]) begin
				sel = fret_sel_t'(1) << (b + 1);
			end
		end
		return sel;
	endfunction

	// one bit per struck string at the chosen position
	function automatic note_t encode(chord_t c);
		note_t n;
		n = '0;
		for (int p = 0; p < NUM_POSITIONS; p++) begin
			for (int s = 0; s < NUM_STRINGS; s++) begin
				n[p*NUM_STRINGS + s] = c.frets[p] & c.strings[s];
			end
		end
		return n;
	endfunction

	always_comb begin
		pressed       = top_bar(frets);
		chord.strings = held.strings | strings;
		// one-hot compare, a higher bar is the larger value
		chord.frets   = (pressed > held.frets) ? pressed : held.frets;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			held <= '0;
		end else if (beat) begin
			held <= '0; // start the next chord
		end else begin
			held <= chord;
		end
	end

	always_ff @(posedge clk) begin
		if (beat) begin
			note <= encode(chord);
		end
	end

	fret_at_most_one_hot: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0(held.frets))
		else $error("gathered fret position is not one-hot");

endmodule

/* verilog/session_control.sv */
// select and back are debounced one-cycle presses and a select held from IDLE runs through ARMED to RUN
module session_control import recorder_pkg::*; (
	input  logic     clk,
	input  logic     resetn,
	input  logic     select,
	input  logic     back,
	input  logic     mode,
	output session_t session
);

	session_state_t state;
	session_state_t state_next;
	logic           mode_q;  // record or play, fixed for the session
	logic           running;

	//////////////////////////////
	// next state
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (select) begin
					state_next = ARMED;
				end
			end
			ARMED: begin
				if (back) begin
					state_next = IDLE;
				end else if (select) begin
					state_next = ARMED_RELEASE;
				end
			end
			ARMED_RELEASE: begin
				if (!select) begin
					state_next = RUN;
				end
			end
			RUN: begin
				if (select) begin
					state_next = RUN_RELEASE; // stop request
				end
			end
			RUN_RELEASE: begin
				if (!select) begin
					state_next = DONE;
				end
			end
			DONE: begin
				if (select || back) begin
					state_next = DONE_RELEASE;
				end
			end
			DONE_RELEASE: begin
				if (!select) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state  <= IDLE;
			mode_q <= MODE_PLAY;
		end else begin
			state <= state_next;
			if (state == IDLE && select) begin
				mode_q <= mode; // latched on the way out of IDLE
			end
		end
	end

	//////////////////////////////
	// session flags
	assign running           = (state == RUN) || (state == RUN_RELEASE);
	assign session.recording = running && (mode_q == MODE_RECORD);
	assign session.playing   = running && (mode_q == MODE_PLAY);
	assign session.rewind    = (state == ARMED) || (state == ARMED_RELEASE);

	rec_play_exclusive: assert property (@(posedge clk) disable iff (!resetn)
		!(session.recording && session.playing))
		else $error("recording and playing both active");

endmodule

/* verilog/note_store.sv */
// one address serves record and play and a take longer than 64 notes wraps over its own start
module note_store import fretboard_pkg::*; import recorder_pkg::*; (
	input  logic     clk,
	input  logic     resetn,
	input  logic     beat,
	input  note_t    note,
	input  session_t session,
	output note_t    note_out
);

	note_t mem [MEM_DEPTH];
	addr_t addr;
	logic  beat_q;  // fresh chord note is valid here
	note_t play_q;  // note read back from memory
	logic  rec_now;
	logic  play_now;

	assign rec_now  = session.recording && beat_q;
	assign play_now = session.playing && beat;

	//////////////////////////////
	// record/play address
	always_ff @(posedge clk) begin
		if (!resetn) begin
			beat_q <= 1'b0;
			addr   <= '0;
		end else begin
			beat_q <= beat;
			if (session.rewind) begin
				addr <= '0;
			end else if (rec_now || play_now) begin
				addr <= addr + 1'b1; // wraps at the top
			end
		end
	end

	//////////////////////////////
	// note memory
	always_ff @(posedge clk) begin
		if (rec_now) begin
			mem[addr] <= note;
		end
	end

	// read on the beat so the note shows the cycle after
	always_ff @(posedge clk) begin
		if (session.rewind) begin
			play_q <= '0;
		end else if (play_now) begin
			play_q <= mem[addr];
		end
	end

	always_comb begin
		if (session.recording) begin
			note_out = note; // live chord while recording
		end else if (session.playing) begin
			note_out = play_q;
		end else begin
			note_out = '0;
		end
	end

	written_note_fits: assert property (@(posedge clk) disable iff (!resetn)
		rec_now |-> (note[NOTE_W-1 -: 2] == 2'b00))
		else $error("note written with upper bits set");

endmodule

/* verilog/note_display.sv */
// shows a single-string note as two bit indices and any other half of the note shows as F
module note_display import fretboard_pkg::*; (
	input  note_t     note,
	output segments_t hex_low,
	output segments_t hex_high
);

	logic [3:0] digit_low;  // bits 15..0
	logic [3:0] digit_high; // bits 31..16

	// index of the only set bit, F when the half is not one-hot
	function automatic logic [3:0] bit_index(logic [15:0] half);
		logic [3:0] idx;
		idx = 4'hF;
		if ($onehot(half)) begin
			for (int i = 0; i < 16; i++) begin
				if (half[i]) begin
					idx = 4'(i);
				end
			end
		end
		return idx;
	endfunction

	//////////////////////////////
	// digit select
	assign digit_low  = bit_index(note[15:0]);
	assign digit_high = bit_index(note[NOTE_W-1:16]);

	// segment lookup
	assign hex_low  = SEG_TABLE[digit_low];
	assign hex_high = SEG_TABLE[digit_high];

endmodule

/* verilog/guitar_recorder.sv */
// buttons and pads must arrive synchronous and debounced and tick_cycles sets clock cycles per tick
module guitar_recorder import fretboard_pkg::*; import recorder_pkg::*; #(
	parameter int tick_cycles = 50000 // 1 ms at 50 MHz
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  string_mask_t         strings,
	input  logic [NUM_FRETS-1:0] frets,
	input  speed_t               speed,
	input  logic                 mode,
	input  logic                 select,
	input  logic                 back,
	output logic                 beat,     // metronome light
	output note_t                note_out,
	output segments_t            hex_low,
	output segments_t            hex_high
);

	note_t    note;
	session_t session;

	beat_timer #(.tick_cycles(tick_cycles)) u_beat_timer (
		.clk, .resetn, .speed, .beat
	);

	chord_capture u_chord_capture (
		.clk, .resetn, .strings, .frets, .beat, .note
	);

	session_control u_session_control (
		.clk, .resetn, .select, .back, .mode, .session
	);

	note_store u_note_store (
		.clk, .resetn, .beat, .note, .session, .note_out
	);

	note_display u_note_display (
		.note(note_out), .hex_low, .hex_high
	);

endmodule

/* verif/guitar_recorder_tb.sv */
// runs at speed 7 with one cycle per tick and reads the golden file relative to the project root
module guitar_recorder_tb import fretboard_pkg::*; import recorder_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BEAT_TIMEOUT = 400;
	localparam int FIRST_BEAT   = 273; // speed 7 at one cycle per tick

	// standard hex digits, gfedcba active low
	localparam segments_t HEX_PATTERNS [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	logic                 clk;
	logic                 resetn;
	string_mask_t         strings;
	logic [NUM_FRETS-1:0] frets;
	speed_t               speed;
	logic                 mode;
	logic                 select;
	logic                 back;
	logic                 beat;
	note_t                note_out;
	segments_t            hex_low;
	segments_t            hex_high;

	int tests_run;
	int tests_failed;
	bit test_ok;
	bit timed_out;

	guitar_recorder #(.tick_cycles(1)) DUT (
		.clk, .resetn, .strings, .frets, .speed, .mode, .select, .back,
		.beat, .note_out, .hex_low, .hex_high
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// reference helpers
	function automatic logic [3:0] expected_digit(logic [15:0] half);
		int         ones;
		logic [3:0] idx;
		ones = 0;
		idx  = 4'hF;
		for (int i = 0; i < 16; i++) begin
			if (half[i]) begin
				ones++;
				idx = 4'(i);
			end
		end
		if (ones != 1) begin
			idx = 4'hF; // blank or chord shows F
		end
		return idx;
	endfunction

	// random bars strictly below the highest one pressed
	function automatic logic [3:0] random_lower_bars(logic [3:0] bars);
		logic [3:0] below;
		below = 4'b0000;
		for (int b = 0; b < NUM_FRETS; b++) begin
			if (bars[b]) begin
				below = (4'b0001 << b) - 4'b0001;
			end
		end
		return 4'($urandom) & below;
	endfunction

	task automatic check_outputs(input string name, input note_t expected);
		segments_t exp_low;
		segments_t exp_high;
		exp_low  = HEX_PATTERNS[expected_digit(expected[15:0])];
		exp_high = HEX_PATTERNS[expected_digit(expected[31:16])];
		if (note_out !== expected) begin
			$display("ERROR %s note_out expected %h actual %h", name, expected, note_out);
			test_ok = 1'b0;
		end
		if (hex_low !== exp_low) begin
			$display("ERROR %s hex_low expected %b actual %b", name, exp_low, hex_low);
			test_ok = 1'b0;
		end
		if (hex_high !== exp_high) begin
			$display("ERROR %s hex_high expected %b actual %b", name, exp_high, hex_high);
			test_ok = 1'b0;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_ok) begin
			$display("%s ok", name);
		end else begin
			tests_failed++;
			$display("%s fail", name);
		end
		test_ok = 1'b1;
	endtask

	//////////////////////////////
	// stimulus
	task automatic wait_beat(input string name, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!beat && cycles < BEAT_TIMEOUT);
		if (!beat) begin
			timed_out = 1'b1;
			$display("no beat within %0d cycles during %s", BEAT_TIMEOUT, name);
		end
	endtask

	task automatic press(input bit use_back);
		select = !use_back;
		back   = use_back;
		@(negedge clk);
		select = 1'b0;
		back   = 1'b0;
		@(negedge clk);
	endtask

	task automatic start_session(input logic run_mode);
		mode = run_mode;
		press(1'b0); // to ARMED
		press(1'b0); // through ARMED_RELEASE to RUN
	endtask

	task automatic stop_session();
		press(1'b0); // to DONE
		press(1'b0); // back to IDLE
	endtask

	task automatic play_line(input string name, input string_mask_t str_a, input logic [3:0] fret_a,
		input string_mask_t str_b, input logic [3:0] fret_b, input note_t expected);
		int waited;
		strings = str_a;
		frets   = fret_a;
		@(negedge clk);
		strings = str_b;
		frets   = fret_b;
		@(negedge clk);
		strings = '0;
		frets   = random_lower_bars(fret_a | fret_b);
		@(negedge clk);
		frets = '0;
		wait_beat(name, waited);
		if (!timed_out) begin
			@(negedge clk); // note shows the cycle after beat
			check_outputs(name, expected);
			end_test(name);
		end
	endtask

	initial begin
		int           fd;
		int           n;
		int           waited;
		int           active_mode;
		string        line;
		string        name;
		logic         mode_v;
		string_mask_t str_a;
		string_mask_t str_b;
		logic [3:0]   fret_a;
		logic [3:0]   fret_b;
		note_t        exp_note;
		void'($urandom(32'h11c6afee));
		resetn       = 1'b0;
		strings      = '0;
		frets        = '0;
		speed        = 3'd7;
		mode         = MODE_PLAY;
		select       = 1'b0;
		back         = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		test_ok      = 1'b1;
		timed_out    = 1'b0;
		active_mode  = -1;
		repeat (4) @(negedge clk);
		resetn = 1'b1;
		check_outputs("reset", '0);
		end_test("reset");

		wait_beat("first_beat", waited);
		if (!timed_out) begin
			if (waited != FIRST_BEAT) begin
				$display("ERROR first_beat cycles expected %0d actual %0d", FIRST_BEAT, waited);
				test_ok = 1'b0;
			end
			end_test("first_beat");
		end

		fd = $fopen("verif/guitar_recorder_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/guitar_recorder_golden.txt");
			tests_failed++;
		end else begin
			while (!timed_out && $fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %h %h %h %h %h %h", name, mode_v,
						str_a, fret_a, str_b, fret_b, exp_note);
					if (n != 7) begin
						$display("golden line not understood: %s", line);
						tests_failed++;
					end else begin
						if (int'(mode_v) != active_mode) begin
							if (active_mode >= 0) begin
								stop_session();
							end
							start_session(mode_v); // record and play share one address
							active_mode = int'(mode_v);
						end
						play_line(name, str_a, fret_a, str_b, fret_b, exp_note);
					end
				end
			end
			$fclose(fd);
		end

		// back while armed, then select only arms again from idle
		if (active_mode < 0) begin
			$display("the golden file held no test lines");
			tests_failed++;
		end else if (!timed_out) begin
			stop_session();
			mode = MODE_PLAY;
			press(1'b0);
			check_outputs("back_from_armed", '0);
			press(1'b1);
			check_outputs("back_from_armed", '0);
			press(1'b0);
			wait_beat("back_from_armed", waited);
			if (!timed_out) begin
				@(negedge clk);
				check_outputs("back_from_armed", '0); // a replay here means back was ignored
				end_test("back_from_armed");
			end
		end

		$display("%0d tests run, %0d failed", tests_run, tests_failed);
		if (tests_failed == 0 && !timed_out) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* verif/guitar_recorder_golden.txt */
# name mode strings_a frets_a strings_b frets_b expected_note, all values in hex
# mode 1 records and 0 plays back; pads a and b are struck in two successive cycles of one beat
rec_open_s0 1 01 0 00 0 00000001
rec_bar1_s2 1 04 1 00 0 00000100
rec_bar4_s5 1 20 8 00 0 20000000
rec_or_strings 1 03 0 0c 0 0000000f
rec_high_bar_wins 1 01 1 02 4 000c0000
rec_bar2_s4 1 10 2 00 0 00010000
rec_lower_after_higher 1 08 8 01 2 09000000
rec_silent 1 00 4 00 0 00000000
rec_all_bar3 1 3f 4 00 0 00fc0000
rec_bar3_s1 1 02 6 00 0 00080000
play_0 0 3f f 15 3 00000001
play_1 0 00 0 00 0 00000100
play_2 0 21 2 00 0 20000000
play_3 0 00 0 0c 8 0000000f
play_4 0 3f f 15 3 000c0000
play_5 0 00 0 00 0 00010000
play_6 0 01 1 00 0 09000000
play_7 0 00 0 3f 4 00000000
play_8 0 12 8 00 0 00fc0000
play_9 0 00 0 00 0 00080000

/* guitar_recorder.f */
verilog/fretboard_pkg.sv
verilog/recorder_pkg.sv
verilog/beat_timer.sv
verilog/chord_capture.sv
verilog/session_control.sv
verilog/note_store.sv
verilog/note_display.sv
verilog/guitar_recorder.sv
verif/guitar_recorder_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run from the project root so the golden file is found
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module guitar_recorder_tb \
	-f guitar_recorder.f -o guitar_recorder_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/guitar_recorder_sim > sim.log 2>&1
cat sim.log
grep -q "All tests passed" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
